/* verification/beam_tests.txt */
# test <name> <fmt 0 real 1 complex> <burst length> <bursts, below 4 ends in reset>
# then one line of hex samples per burst 0..3, then a line of expected averages
test real_avg 0 5 4
00000004 00000001 FFFFFFFF 7FFFFFFF 80000000
00000008 00000001 FFFFFFFE 7FFFFFFF 80000000
0000000C 00000001 FFFFFFFD 7FFFFFFF 80000000
00000010 00000000 FFFFFFFC 7FFFFFFF 80000000
0000000A 00000000 FFFFFFFD 7FFFFFFF 80000000
test complex_neg 1 4 4
0001FFFF 80007FFF FFFE0003 12348001
0002FFFF 80007FFF FFFF0002 12348001
0003FFFF 80007FFF 00000001 12348000
0004FFFF 80007FFF 00010001 12348000
0002FFFF 80007FFF FFFF0001 12348000
test ack_backpressure 0 8 4
0 4 8 C 10 14 18 1C
1 1 1 1 1 1 1 1
1 1 1 1 1 1 1 1
1 1 1 1 1 1 1 1
0 1 2 3 4 5 6 7
test full_depth 0 16 4
0 4 8 C 10 14 18 1C 20 24 28 2C 30 34 38 3C
2 2 2 2 2 2 2 2 2 2 2 2 2 2 2 2
1 1 1 1 1 1 1 1 1 1 1 1 1 1 1 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 2 3 4 5 6 7 8 9 A B C D E F
test reset_mid 0 3 2
11 22 33
44 55 66
test after_reset 1 2 4
0010FFF0 7FFF0000
0020FFE0 7FFF0000
0030FFD0 7FFF0000
0040FFC0 7FFE0000
0028FFD8 7FFE0000

/* vlog.f */
hdl/beam_data_pkg.sv
hdl/beam_cfg_pkg.sv
hdl/sample_fifo.sv
hdl/beam_buffer.sv
hdl/beam_summer.sv
hdl/beam_out_port.sv
hdl/beam_top.sv
verification/beam_clk_gen.sv
verification/beam_checker.sv
verification/beam_tb_chk.sv
verification/beam_tb.sv

/* verification/beam_tb.sv */
// --------------------
// Reads verification/beam_tests.txt relative to the project root
// Inputs change on falling edges
// Output words are compared in beam_checker
// A test with fewer than 4 bursts ends in a reset
// --------------------
module beam_tb import beam_data_pkg::*, beam_cfg_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int FIFO_AW    = 4;

    logic         clk;
    logic         reset;
    sample_fmt_e  fmt;
    logic         burst;
    logic         wr_en;
    beam_sample_u wr_data;
    logic         ack;
    logic         req;
    beam_sample_u data;

    // Test table with flat sample and expected lists
    string               t_name[$];
    int                  t_fmt[$];
    int                  t_len[$];
    int                  t_nblk[$];
    logic [SAMPLE_W-1:0] t_samp[$];
    logic [SAMPLE_W-1:0] t_exp[$];

    integer seed;
    integer ack_seed;
    int     limit_cycles = 0;

    beam_clk_gen #(
        .PERIOD (CLK_PERIOD)
    ) u_clk_gen (
        .o_clk (clk)
    );

    beam_top #(
        .FIFO_AW (FIFO_AW)
    ) i_dut (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_fmt     (fmt),
        .i_burst   (burst),
        .i_wr_en   (wr_en),
        .i_wr_data (wr_data),
        .i_ack     (ack),
        .o_req     (req),
        .o_data    (data)
    );

    beam_checker u_checker (
        .i_clk   (clk),
        .i_reset (reset),
        .i_req   (req),
        .i_ack   (ack),
        .i_data  (data)
    );

    // --------------------
    // Test file
    // --------------------

    // Each record is test name fmt len nblk
    // followed by nblk*len samples and len expected words
    task automatic load_tests();
        int                  fd;
        int                  code;
        int                  fmt_v;
        int                  len_v;
        int                  nblk_v;
        int                  nexp;
        string               tok;
        string               name;
        string               rest;
        logic [SAMPLE_W-1:0] word;

        fd = $fopen("verification/beam_tests.txt", "r");
        if (fd == 0) begin
            u_checker.note_failure("cannot open verification/beam_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1)
                break;
            if (tok[0] == "#") begin
                // Rest of a comment line
                code = $fgets(rest, fd);
            end else if (tok == "test") begin
                code = $fscanf(fd, "%s %d %d %d", name, fmt_v, len_v, nblk_v);
                t_name.push_back(name);
                t_fmt.push_back(fmt_v);
                t_len.push_back(len_v);
                t_nblk.push_back(nblk_v);
                for (int n = 0; n < nblk_v * len_v; n++) begin
                    code = $fscanf(fd, "%h", word);
                    t_samp.push_back(word);
                end
                // Only a full beam line produces outputs
                nexp = (nblk_v == NUM_BLOCKS) ? len_v : 0;
                for (int n = 0; n < nexp; n++) begin
                    code = $fscanf(fd, "%h", word);
                    t_exp.push_back(word);
                end
            end else begin
                u_checker.note_failure($sformatf("unknown word %s in test file", tok));
                break;
            end
        end
        $fclose(fd);
        if (t_name.size() == 0)
            u_checker.note_failure("test file holds no tests");
    endtask

    // --------------------
    // Stimulus
    // --------------------

    // One burst with 0 to 2 idle cycles before each sample
    task automatic drive_burst(input int base, input int len);
        int gap;

        burst = 1'b1;
        for (int n = 0; n < len; n++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
            wr_en   = 1'b1;
            wr_data = t_samp[base + n];
            @(negedge clk);
            wr_en = 1'b0;
        end
        burst = 1'b0;
        // Block index moves on before the next burst
        repeat (2) @(negedge clk);
    endtask

    // Reset over 4 rising edges
    // o_req must be low once it is released
    task automatic apply_reset();
        reset = 1'b1;
        burst = 1'b0;
        wr_en = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        if (req !== 1'b0)
            u_checker.note_failure("o_req is not low after reset");
    endtask

    task automatic run_test(input int t, input int sbase, input int ebase);
        int len;

        len = t_len[t];
        fmt = (t_fmt[t] != 0) ? FMT_COMPLEX : FMT_REAL;
        u_checker.open_test(t_name[t]);
        if (t_nblk[t] == NUM_BLOCKS) begin
            for (int n = 0; n < len; n++)
                u_checker.expect_word(t_exp[ebase + n]);
        end
        for (int b = 0; b < t_nblk[t]; b++)
            drive_burst(sbase + b * len, len);
        if (t_nblk[t] < NUM_BLOCKS) begin
            // Partial beam line is abandoned by reset
            apply_reset();
        end else begin
            while (u_checker.pending() != 0)
                @(negedge clk);
        end
        u_checker.close_test();
    endtask

    // --------------------
    // Sink side acks after 0 to 5 cycles
    // --------------------
    initial begin : ack_responder
        int delay;

        ack = 1'b0;
        forever begin
            @(negedge clk);
            if (req && !reset) begin
                delay = $unsigned($random(ack_seed)) % 6;
                repeat (delay) @(negedge clk);
                ack = 1'b1;
                do
                    @(negedge clk);
                while (req);
                ack = 1'b0;
            end
        end
    end

    // Limit from the total sample count
    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        u_checker.report_missing();
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main_flow
        int sbase;
        int ebase;
        int assert_fails;

        reset    = 1'b1;
        fmt      = FMT_REAL;
        burst    = 1'b0;
        wr_en    = 1'b0;
        wr_data  = '0;
        seed     = 32'hc3f27183;
        ack_seed = $random(seed);
        load_tests();
        limit_cycles = 50 * t_samp.size() + 200;

        apply_reset();

        sbase = 0;
        ebase = 0;
        for (int t = 0; t < t_name.size(); t++) begin
            run_test(t, sbase, ebase);
            sbase += t_nblk[t] * t_len[t];
            if (t_nblk[t] == NUM_BLOCKS)
                ebase += t_len[t];
        end

        // Room for any stray output to show up
        repeat (20) @(negedge clk);
        assert_fails = i_dut.u_tb_chk.fail_count;
        u_checker.print_counts(assert_fails);
        if (u_checker.error_count == 0 && assert_fails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verification/beam_tb_chk.sv */
// --------------------
// Bound into beam_top to watch handshake and FIFO rules
// Reads buffer internals by hierarchical name
// --------------------
module beam_tb_chk import beam_data_pkg::*, beam_cfg_pkg::*; (
    input logic                  i_clk,
    input logic                  i_reset,
    input logic                  i_req,
    input logic                  i_ack,
    input logic [SAMPLE_W-1:0]   i_data,
    input logic [NUM_BLOCKS-1:0] i_fifo_wr,
    input logic [NUM_BLOCKS-1:0] i_fifo_full,
    input logic                  i_pop
);

    int fail_count = 0;

    // Words written minus words popped, per FIFO
    int                    level [NUM_BLOCKS];
    logic [NUM_BLOCKS-1:0] has_word;

    // --------------------
    // Shadow fill levels
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int k = 0; k < NUM_BLOCKS; k++)
                level[k] <= 0;
        end else begin
            for (int k = 0; k < NUM_BLOCKS; k++)
                level[k] <= level[k] + int'(i_fifo_wr[k]) - int'(i_pop);
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_BLOCKS; k++)
            has_word[k] = (level[k] > 0);
    end

    // Word must not move under a pending request
    a_data_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        i_req && $past(i_req) |-> $stable(i_data))
    else begin
        $error("o_data changed while o_req was high");
        fail_count++;
    end

    // Req rise decided while ack was low
    a_req_rise: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_req) |-> !$past(i_ack))
    else begin
        $error("o_req rose while i_ack was still high");
        fail_count++;
    end

    // Burst longer than one FIFO depth
    a_no_full_write: assert property (@(posedge i_clk) disable iff (i_reset)
        !(|(i_fifo_wr & i_fifo_full)))
    else begin
        $error("write reached a full FIFO");
        fail_count++;
    end

    // Every FIFO holds a written word when the buffer pops
    a_no_empty_pop: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pop |-> (&has_word))
    else begin
        $error("pop issued while a FIFO was empty");
        fail_count++;
    end

endmodule

bind beam_top beam_tb_chk u_tb_chk (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_req       (o_req),
    .i_ack       (i_ack),
    .i_data      (o_data),
    .i_fifo_wr   (u_buffer.wr_en_q),
    .i_fifo_full (u_buffer.fifo_full),
    .i_pop       (u_buffer.pop)
);

/* verification/beam_checker.sv */
// --------------------
// Scoreboard for the four-phase output port
// Expected words are queued per test, compared in order
// One output is taken per req/ack overlap
// --------------------
module beam_checker import beam_data_pkg::*; (
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_req,
    input  logic         i_ack,
    input  beam_sample_u i_data
);

    string               cur_name = "setup";
    logic [SAMPLE_W-1:0] exp_q[$];
    int                  error_count = 0;
    int                  test_errors = 0;
    int                  test_count = 0;
    int                  word_count = 0;
    int                  test_words = 0;
    // Set once the current handshake has been compared
    logic                taken;

    // --------------------
    // Calls from the testbench
    // --------------------
    task automatic open_test(input string name);
        cur_name    = name;
        test_errors = 0;
        test_words  = 0;
        exp_q.delete();
    endtask

    task automatic expect_word(input logic [SAMPLE_W-1:0] word);
        exp_q.push_back(word);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    // Plain-language failure, counted with the mismatches
    task automatic note_failure(input string msg);
        $display("%s: %s", cur_name, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic close_test();
        test_count++;
        if (test_errors == 0)
            $display("PASS %s, %0d outputs", cur_name, test_words);
        else
            $display("FAIL %s, %0d problems", cur_name, test_errors);
    endtask

    // Used by the watchdog
    task automatic report_missing();
        if (exp_q.size() != 0)
            note_failure($sformatf("%0d expected outputs never arrived", exp_q.size()));
    endtask

    task automatic print_counts(input int assert_fails);
        $display("Tests %0d, outputs checked %0d, failed checks %0d, assertion failures %0d",
                 test_count, word_count, error_count, assert_fails);
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(posedge i_clk) begin : monitor
        logic [SAMPLE_W-1:0] want;

        if (i_reset) begin
            taken = 1'b0;
        end else if (i_req && i_ack && !taken) begin
            taken = 1'b1;
            word_count++;
            test_words++;
            if (exp_q.size() == 0) begin
                note_failure($sformatf("unexpected output %h", i_data));
            end else begin
                want = exp_q.pop_front();
                if (i_data !== want) begin
                    $display("ERROR %s: expected %h, actual %h", cur_name, want, i_data);
                    error_count++;
                    test_errors++;
                end
            end
        end else if (!i_req) begin
            // Req dropped, next rise is a new word
            taken = 1'b0;
        end
    end

endmodule

/* verification/beam_clk_gen.sv */
// --------------------
// Free-running testbench clock, starts low
// --------------------
module beam_clk_gen #(
    parameter int PERIOD = 8
) (
    output logic o_clk
);

    // Half period high, half low
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

/* hdl/beam_top.sv */
// --------------------
// Beam assembly, buffer then summer then output port
// Four bursts per beam line, i_fmt held for the whole line
// Source must not exceed 2**FIFO_AW samples per burst
// --------------------
module beam_top import beam_data_pkg::*, beam_cfg_pkg::*; #(
    parameter int FIFO_AW = 4
) (
    input  logic         i_clk,
    input  logic         i_reset,
    input  sample_fmt_e  i_fmt,
    input  logic         i_burst,
    input  logic         i_wr_en,
    input  beam_sample_u i_wr_data,
    input  logic         i_ack,
    output logic         o_req,
    output beam_sample_u o_data
);

    // Buffer to summer
    logic                           blk_vld;
    logic                           blk_rdy;
    logic [NUM_BLOCKS*SAMPLE_W-1:0] blk_data;

    // Summer to output port
    logic         sum_vld;
    logic         sum_rdy;
    beam_sample_u sum_data;

    beam_buffer #(
        .FIFO_AW (FIFO_AW)
    ) u_buffer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_burst    (i_burst),
        .i_wr_en    (i_wr_en),
        .i_wr_data  (i_wr_data),
        .i_rdy      (blk_rdy),
        .o_blk_vld  (blk_vld),
        .o_blk_data (blk_data)
    );

    beam_summer u_summer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_fmt      (i_fmt),
        .i_blk_vld  (blk_vld),
        .i_blk_data (blk_data),
        .o_rdy      (blk_rdy),
        .i_rdy      (sum_rdy),
        .o_sum_vld  (sum_vld),
        .o_sum_data (sum_data)
    );

    beam_out_port u_out_port (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_sum_vld  (sum_vld),
        .i_sum_data (sum_data),
        .o_rdy      (sum_rdy),
        .i_ack      (i_ack),
        .o_req      (o_req),
        .o_data     (o_data)
    );

endmodule

/* hdl/beam_out_port.sv */
// --------------------
// Four-phase req/ack master with one holding register
// o_data is stable from req rise until the register frees
// --------------------
module beam_out_port import beam_data_pkg::*; (
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_sum_vld,
    input  beam_sample_u i_sum_data,
    output logic         o_rdy,
    input  logic         i_ack,
    output logic         o_req,
    output beam_sample_u o_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RELEASE
    } state_e;

    state_e state_q;
    logic   full_q;

    assign o_rdy = ~full_q;
    assign o_req = (state_q == ST_REQ);

    // --------------------
    // Handshake FSM
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= ST_IDLE;
            full_q  <= 1'b0;
        end else begin
            if (i_sum_vld & o_rdy)
                full_q <= 1'b1;
            case (state_q)
                // Raise req a cycle after load, and only with ack low
                ST_IDLE:    if (full_q & ~i_ack) state_q <= ST_REQ;
                // Sink has taken the word
                ST_REQ:     if (i_ack) state_q <= ST_RELEASE;
                // Ack dropped, register is free again
                ST_RELEASE: if (~i_ack) begin
                    state_q <= ST_IDLE;
                    full_q  <= 1'b0;
                end
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    // Holding register, loads only while empty
    always_ff @(posedge i_clk) begin
        if (i_sum_vld & o_rdy)
            o_data <= i_sum_data;
    end

endmodule

/* hdl/beam_summer.sv */
// --------------------
// Averages four aligned samples, sum then shift right by 2
// Shift rounds toward minus infinity
// Complex lanes are summed apart, no carry between I and Q
// --------------------
module beam_summer import beam_data_pkg::*, beam_cfg_pkg::*; (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  sample_fmt_e                    i_fmt,
    input  logic                           i_blk_vld,
    input  logic [NUM_BLOCKS*SAMPLE_W-1:0] i_blk_data,
    output logic                           o_rdy,
    input  logic                           i_rdy,
    output logic                           o_sum_vld,
    output beam_sample_u                   o_sum_data
);

    beam_sample_u sum_d;
    logic         xfer;

    // --------------------
    // Adder tree
    // --------------------
    always_comb begin
        beam_sample_u              word;
        logic signed [SAMPLE_W+1:0] re_acc;
        logic signed [LANE_W+1:0]   i_acc;
        logic signed [LANE_W+1:0]   q_acc;
        logic signed [SAMPLE_W+1:0] re_sh;
        logic signed [LANE_W+1:0]   i_sh;
        logic signed [LANE_W+1:0]   q_sh;

        re_acc = '0;
        i_acc  = '0;
        q_acc  = '0;
        // Two guard bits cover the sum of four
        for (int k = 0; k < NUM_BLOCKS; k++) begin
            word   = beam_sample_u'(i_blk_data[k*SAMPLE_W +: SAMPLE_W]);
            re_acc = re_acc + word.re;
            i_acc  = i_acc + word.iq.i;
            q_acc  = q_acc + word.iq.q;
        end

        // Divide by four
        re_sh = re_acc >>> 2;
        i_sh  = i_acc >>> 2;
        q_sh  = q_acc >>> 2;

        // Result always fits back into the original width
        if (i_fmt == FMT_COMPLEX) begin
            sum_d.iq.i = i_sh[LANE_W-1:0];
            sum_d.iq.q = q_sh[LANE_W-1:0];
        end else begin
            sum_d.re = re_sh[SAMPLE_W-1:0];
        end
    end

    // --------------------
    // Result register
    // --------------------

    // Accept when empty or being emptied this edge
    assign o_rdy = ~o_sum_vld | i_rdy;
    assign xfer  = i_blk_vld & o_rdy;

    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_sum_vld <= 1'b0;
        else if (o_rdy)
            o_sum_vld <= i_blk_vld;
    end

    // Payload only
    always_ff @(posedge i_clk) begin
        if (xfer)
            o_sum_data <= sum_d;
    end

endmodule

/* hdl/beam_buffer.sv */
// --------------------
// Four-burst beam buffer, burst k goes to FIFO k
// No input back-pressure, a burst must fit in one FIFO
// Read-out starts once every FIFO holds data
// --------------------
module beam_buffer import beam_data_pkg::*, beam_cfg_pkg::*; #(
    parameter int FIFO_AW = 4
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_burst,
    input  logic                           i_wr_en,
    input  logic [SAMPLE_W-1:0]            i_wr_data,
    input  logic                           i_rdy,
    output logic                           o_blk_vld,
    output logic [NUM_BLOCKS*SAMPLE_W-1:0] o_blk_data
);

    // Burst framing
    logic                 burst_d;
    logic                 burst_fall;
    logic [BLK_IDX_W-1:0] blk_idx;

    // Write steering stage
    logic [NUM_BLOCKS-1:0] wr_en_q;
    logic [SAMPLE_W-1:0]   wr_data_q;

    // FIFO status
    logic [NUM_BLOCKS-1:0] fifo_empty;
    logic [NUM_BLOCKS-1:0] fifo_full;
    logic [NUM_BLOCKS-1:0] fifo_vld;

    // Read control
    logic pop;
    logic hold_q;

    // --------------------
    // Block index
    // --------------------

    // Falling edge of burst-active ends a sub-aperture
    always_ff @(posedge i_clk) begin
        if (i_reset)
            burst_d <= 1'b0;
        else
            burst_d <= i_burst;
    end

    assign burst_fall = burst_d & ~i_burst;

    // 2-bit index wraps 3 to 0 by itself
    always_ff @(posedge i_clk) begin
        if (i_reset)
            blk_idx <= '0;
        else if (burst_fall)
            blk_idx <= blk_idx + 1'b1;
    end

    // --------------------
    // Write steering
    // --------------------

    // One-hot enable picks the FIFO of the current block
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_en_q <= '0;
        end else begin
            for (int k = 0; k < NUM_BLOCKS; k++)
                wr_en_q[k] <= i_wr_en & (blk_idx == k[BLK_IDX_W-1:0]);
        end
    end

    // Data register is shared, only the enable selects
    always_ff @(posedge i_clk) begin
        wr_data_q <= i_wr_data;
    end

    // --------------------
    // FIFOs
    // --------------------
    for (genvar gi = 0; gi < NUM_BLOCKS; gi++) begin : g_fifo
        sample_fifo #(
            .FIFO_AW (FIFO_AW)
        ) u_fifo (
            .i_clk      (i_clk),
            .i_reset    (i_reset),
            .i_wr_en    (wr_en_q[gi]),
            .i_din      (wr_data_q),
            .i_rd_en    (pop),
            .o_dout     (o_blk_data[gi*SAMPLE_W +: SAMPLE_W]),
            .o_dout_vld (fifo_vld[gi]),
            .o_empty    (fifo_empty[gi]),
            .o_full     (fifo_full[gi])
        );
    end

    // --------------------
    // Lockstep read-out
    // --------------------

    // All four pop together, so aligned samples leave together
    // Slot must be free or handed over on this edge
    assign pop = ~(|fifo_empty) & (~o_blk_vld | i_rdy);

    // FIFO outputs hold their word, so only the valid needs keeping
    always_ff @(posedge i_clk) begin
        if (i_reset)
            hold_q <= 1'b0;
        else
            hold_q <= o_blk_vld & ~i_rdy;
    end

    // Fresh pop or a word still waiting for the summer
    assign o_blk_vld = (&fifo_vld) | hold_q;

endmodule

/* hdl/sample_fifo.sv */
// --------------------
// Synchronous FIFO, 2**FIFO_AW entries
// Write to full and read from empty are dropped
// Output word holds until the next read
// --------------------
module sample_fifo import beam_data_pkg::*; #(
    parameter int FIFO_AW = 4
) (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_wr_en,
    input  logic [SAMPLE_W-1:0] i_din,
    input  logic                i_rd_en,
    output logic [SAMPLE_W-1:0] o_dout,
    output logic                o_dout_vld,
    output logic                o_empty,
    output logic                o_full
);

    localparam int DEPTH = 1 << FIFO_AW;

    logic [SAMPLE_W-1:0] mem [DEPTH];
    logic [FIFO_AW-1:0]  wr_ptr;
    logic [FIFO_AW-1:0]  rd_ptr;
    // One extra bit so full and empty differ
    logic [FIFO_AW:0]    count;
    logic                wr_ok;
    logic                rd_ok;

    assign wr_ok   = i_wr_en & ~o_full;
    assign rd_ok   = i_rd_en & ~o_empty;
    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH[FIFO_AW:0]);

    // --------------------
    // Pointers and fill level
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous read and write leaves count alone
            if (wr_ok & ~rd_ok)
                count <= count + 1'b1;
            else if (rd_ok & ~wr_ok)
                count <= count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge i_clk) begin
        if (wr_ok)
            mem[wr_ptr] <= i_din;
    end

    // --------------------
    // Registered read port
    // --------------------
    always_ff @(posedge i_clk) begin
        if (rd_ok)
            o_dout <= mem[rd_ptr];
    end

    // Valid for one cycle per read
    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_dout_vld <= 1'b0;
        else
            o_dout_vld <= rd_ok;
    end

endmodule

/* hdl/beam_cfg_pkg.sv */
// --------------------
// Beam line configuration types
// Block count is fixed at 4, the summer divides by a shift of 2
// --------------------
package beam_cfg_pkg;

    // --------------------
    // Sample format
    // --------------------

    // Selects how a sample word is decoded
    // Held static for a whole beam line
    typedef enum logic {
        FMT_REAL    = 1'b0,
        FMT_COMPLEX = 1'b1
    } sample_fmt_e;

    // --------------------
    // Aperture split
    // --------------------

    // Sub-aperture bursts per beam line
    // One FIFO per burst in the buffer
    localparam int NUM_BLOCKS = 4;

    // Block index width, wraps 3 to 0
    localparam int BLK_IDX_W = $clog2(NUM_BLOCKS);

endpackage

/* hdl/beam_data_pkg.sv */
// --------------------
// Sample word layout shared by the datapath
// Complex samples put I in the upper half, Q in the lower half
// Both lanes are two's complement
// --------------------
package beam_data_pkg;

    // --------------------
    // Widths
    // --------------------

    // One sample word on every bus
    localparam int SAMPLE_W = 32;

    // One I or Q lane of a complex sample
    localparam int LANE_W = SAMPLE_W / 2;

    // --------------------
    // Views of one word
    // --------------------

    // I lane sits in the upper half
    typedef struct packed {
        logic signed [LANE_W-1:0] i;
        logic signed [LANE_W-1:0] q;
    } beam_iq_s;

    // Same bits, decoded as real or as I/Q
    // Format select lives with the configuration types
    typedef union packed {
        logic signed [SAMPLE_W-1:0] re;
        beam_iq_s                   iq;
    } beam_sample_u;

endpackage
